// File: Makefile
# Verilator build and run for the interrupt vector unit

TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = ivmu_tb
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run passes only if the log holds the pass line
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/ivmu_properties.sv
module ivmu_properties (
    input logic                         clk,
    input logic                         rst,
    input logic                         ready,
    input logic                         valid,
    input logic [ivmu_pkg::SLICE_W-1:0] irq_id,
    input logic [ivmu_pkg::ADDR_W-1:0]  vector_addr,
    input logic                         issue,
    input logic [ivmu_pkg::SLICE_W-1:0] issue_id
);

    timeunit 1ns;
    timeprecision 1ps;

    import ivmu_pkg::*;

    // ==================================================
    // Output handshake properties
    // ==================================================

    // Stage comes out of reset empty
    assert property (@(posedge clk) $fell(rst) |-> !valid)
        else $error("valid high in the first cycle after reset release");

    // Stalled output keeps its contents
    assert property (@(posedge clk) disable iff (rst)
        valid && !ready |=> valid && $stable(vector_addr) && $stable(irq_id))
        else $error("output changed while stalled by ready");

    // A retired line is the one presented on the next cycle
    assert property (@(posedge clk) disable iff (rst)
        issue |=> valid && irq_id == $past(issue_id))
        else $error("issue pulse not followed by a valid output for that line");

endmodule

// Attach to every output stage instance
bind vector_out_stage ivmu_properties u_ivmu_properties (
    .clk         (clk),
    .rst         (rst),
    .ready       (ready),
    .valid       (valid),
    .irq_id      (irq_id),
    .vector_addr (vector_addr),
    .issue       (issue),
    .issue_id    (issue_id)
);

// File: bench/ivmu_tb.sv
module ivmu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import ivmu_pkg::*;

    // ==================================================
    // Phase lengths and run limit
    // ==================================================

    localparam int RESET_CYCLES = 3;
    localparam int ROUND        = NUM_IRQ * DWELL_CYCLES;
    localparam int STEP_RUN     = 80;
    localparam int STEP_HOLD    = 20;
    localparam int EDGE_HOLD    = 2 * ROUND + 8;
    localparam int LOW_GAP      = 4;
    localparam int RE_EDGE_HOLD = ROUND + 8;
    localparam int STALL        = 400;
    localparam int DRAIN        = 2 * ROUND + 8;
    localparam int TABLE_RUN    = 200;
    localparam int MIX_RUN      = 4000;
    localparam int MARGIN       = 200;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + STEP_RUN + STEP_HOLD + EDGE_HOLD
                                  + 2 * LOW_GAP + RE_EDGE_HOLD + STALL + DRAIN
                                  + TABLE_RUN + MIX_RUN + MARGIN;

    // DUT ports
    logic               clk;
    logic               rst;
    logic [NUM_IRQ-1:0] irq_in;
    logic               run;
    logic               tbl_we;
    logic [SLICE_W-1:0] tbl_idx;
    logic [ADDR_W-1:0]  tbl_data;
    logic               ready;
    logic [ADDR_W-1:0]  vector_addr;
    logic [SLICE_W-1:0] irq_id;
    logic               valid;
    logic [SLICE_W-1:0] time_slice;

    // Reference model state
    logic [NUM_IRQ-1:0] m_irq_q;
    logic [NUM_IRQ-1:0] m_pending;
    int                 m_dwell;
    logic [SLICE_W-1:0] m_slice;
    logic [ADDR_W-1:0]  m_table [NUM_IRQ];
    logic               m_valid;
    logic [SLICE_W-1:0] m_irq_id;
    logic [ADDR_W-1:0]  m_addr;

    // Scoreboard, counts and requests between stimulus and monitor
    bit          check_en;
    bit          expect_reset_tbl;
    int          err_count;
    int          check_count;
    int          cycle_cnt;
    int          req_seq;
    int          done_seq;
    logic [31:0] got_cnt  [NUM_IRQ];
    logic [31:0] base_cnt [NUM_IRQ];
    logic [31:0] exp_cnt  [NUM_IRQ];
    int          seed;
    logic [31:0] rnd_a;
    logic [31:0] rnd_b;
    logic [31:0] rnd_c;

    ivmu_top dut (
        .clk         (clk),
        .rst         (rst),
        .irq_in      (irq_in),
        .run         (run),
        .tbl_we      (tbl_we),
        .tbl_idx     (tbl_idx),
        .tbl_data    (tbl_data),
        .ready       (ready),
        .vector_addr (vector_addr),
        .irq_id      (irq_id),
        .valid       (valid),
        .time_slice  (time_slice)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==================================================
    // Reference model
    // ==================================================

    task automatic model_reset();
        m_irq_q   = '0;
        m_pending = '0;
        m_dwell   = 0;
        m_slice   = '0;
        m_valid   = 1'b0;
        m_irq_id  = '0;
        m_addr    = '0;
        // Entry i starts at base plus i strides
        for (int i = 0; i < NUM_IRQ; i++) begin
            m_table[i] = VEC_BASE + 32'(i) * 32'(VEC_STRIDE);
        end
    endtask

    task automatic model_step();
        logic [NUM_IRQ-1:0] rise;
        logic               cand_v;
        logic [ADDR_W-1:0]  cand_a;
        logic               load;
        rise   = irq_in & ~m_irq_q;
        // Only the line of the current slice may compete
        cand_v = m_pending[m_slice];
        cand_a = cand_v ? m_table[m_slice] : '0;
        load   = !m_valid || ready;
        // Retire on load, a fresh edge sets it again
        if (load && cand_v) begin
            m_pending[m_slice] = 1'b0;
        end
        m_pending = m_pending | rise;
        if (load) begin
            m_valid  = cand_v;
            m_irq_id = m_slice;
            m_addr   = cand_a;
        end
        // Write seen by the candidate from the next cycle
        if (tbl_we) begin
            m_table[tbl_idx] = tbl_data;
        end
        if (run) begin
            if (m_dwell == DWELL_CYCLES - 1) begin
                m_dwell = 0;
                m_slice = m_slice + 4'd1;
            end else begin
                m_dwell = m_dwell + 1;
            end
        end
        m_irq_q = irq_in;
    endtask

    // Inputs read here are the values before this edge's updates
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            model_reset();
        end else begin
            model_step();
        end
    end

    // ==================================================
    // Checks at the falling edge
    // ==================================================

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    always @(negedge clk) begin
        if (check_en) begin
            check_value("valid", 32'(valid), 32'(m_valid));
            check_value("irq_id", 32'(irq_id), 32'(m_irq_id));
            check_value("vector_addr", vector_addr, m_addr);
            check_value("time_slice", 32'(time_slice), 32'(m_slice));
            // Per-line delivery counts since the last mark
            if (req_seq != done_seq) begin
                for (int i = 0; i < NUM_IRQ; i++) begin
                    check_value($sformatf("vector count of irq %0d", i),
                                got_cnt[i] - base_cnt[i], exp_cnt[i]);
                end
                done_seq = req_seq;
            end
            // Transfer happens at the coming rising edge
            if (valid && ready) begin
                got_cnt[irq_id] = got_cnt[irq_id] + 1;
                if (expect_reset_tbl) begin
                    check_value("vector_addr", vector_addr,
                                VEC_BASE + 32'(irq_id) * 32'(VEC_STRIDE));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks run: %0d, errors: %0d", check_count, err_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================

    task automatic drive_inputs(input logic [NUM_IRQ-1:0] irq, input logic run_v,
                                input logic rdy, input logic we,
                                input logic [SLICE_W-1:0] idx, input logic [ADDR_W-1:0] data);
        @(posedge clk);
        irq_in   <= irq;
        run      <= run_v;
        ready    <= rdy;
        tbl_we   <= we;
        tbl_idx  <= idx;
        tbl_data <= data;
    endtask

    task automatic roll();
        rnd_a = $random(seed);
        rnd_b = $random(seed);
        rnd_c = $random(seed);
    endtask

    task automatic mark_counts();
        for (int i = 0; i < NUM_IRQ; i++) begin
            base_cnt[i] = got_cnt[i];
        end
    endtask

    // Every line once, one line twice when twice_id is valid
    task automatic expect_counts(input int twice_id);
        for (int i = 0; i < NUM_IRQ; i++) begin
            exp_cnt[i] = (i == twice_id) ? 32'd2 : 32'd1;
        end
        req_seq++;
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        seed = 77;
        for (int i = 0; i < NUM_IRQ; i++) begin
            got_cnt[i] = '0;
        end
        rst      <= 1'b1;
        irq_in   <= '0;
        run      <= 1'b0;
        ready    <= 1'b0;
        tbl_we   <= 1'b0;
        tbl_idx  <= '0;
        tbl_data <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_en = 1'b1;

        // Slice stepping, then a hold with run low
        repeat (STEP_RUN) drive_inputs('0, 1'b1, 1'b1, 1'b0, '0, '0);
        repeat (STEP_HOLD) drive_inputs('0, 1'b0, 1'b1, 1'b0, '0, '0);

        // All lines rise and stay high, one vector each
        expect_reset_tbl = 1'b1;
        mark_counts();
        repeat (EDGE_HOLD) drive_inputs('1, 1'b1, 1'b1, 1'b0, '0, '0);
        expect_counts(-1);

        // New edge on line 5 after its issue
        repeat (LOW_GAP) drive_inputs(16'hFFDF, 1'b1, 1'b1, 1'b0, '0, '0);
        repeat (RE_EDGE_HOLD) drive_inputs('1, 1'b1, 1'b1, 1'b0, '0, '0);
        expect_counts(5);
        repeat (LOW_GAP) drive_inputs('0, 1'b1, 1'b1, 1'b0, '0, '0);

        // Random ready stalls, then drain with ready high
        mark_counts();
        repeat (STALL) begin
            roll();
            drive_inputs('1, 1'b1, rnd_a[0], 1'b0, '0, '0);
        end
        repeat (DRAIN) drive_inputs('1, 1'b1, 1'b1, 1'b0, '0, '0);
        expect_counts(-1);

        // Table rewrites with sparse interrupt traffic
        expect_reset_tbl = 1'b0;
        repeat (TABLE_RUN) begin
            roll();
            drive_inputs(rnd_a[15:0] & rnd_b[15:0], 1'b1, 1'b1, rnd_a[16],
                         rnd_a[20:17], rnd_c);
        end

        // Everything random
        repeat (MIX_RUN) begin
            roll();
            drive_inputs(rnd_a[15:0] & rnd_b[15:0], rnd_a[19:17] != 3'd0,
                         rnd_a[16] | rnd_b[16], rnd_b[20:18] == 3'd0,
                         rnd_b[24:21], rnd_c);
        end

        repeat (2) @(negedge clk);
        $display("Checks run: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: design/irq_pending.sv
module irq_pending (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [ivmu_pkg::NUM_IRQ-1:0] irq_in,
    input  logic                        issue,
    input  logic [ivmu_pkg::SLICE_W-1:0] issue_id,
    output logic [ivmu_pkg::NUM_IRQ-1:0] pending
);

    import ivmu_pkg::*;

    // ==================================================
    // Rising edge detection
    // ==================================================

    // Raw lines as seen on the previous cycle
    logic [NUM_IRQ-1:0] irq_q;

    // One bit per line that went from 0 to 1
    logic [NUM_IRQ-1:0] irq_rise;

    // Bit to retire when the output stage takes a vector
    logic [NUM_IRQ-1:0] clr_mask;

    // Next value of the pending register
    logic [NUM_IRQ-1:0] pending_nxt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_q <= '0;
        end else begin
            irq_q <= irq_in;
        end
    end

    // Line high now and low one cycle ago
    assign irq_rise = irq_in & ~irq_q;

    // ==================================================
    // Pending bits
    // ==================================================

    // One-hot of the issued index, empty without an issue pulse
    assign clr_mask = NUM_IRQ'(issue) << issue_id;

    // Clear first, then set
    // A new edge on the issued line keeps its bit pending
    assign pending_nxt = (pending & ~clr_mask) | irq_rise;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending <= pending_nxt;
        end
    end

endmodule

// File: design/ivmu_pkg.sv
package ivmu_pkg;

    // ==================================================
    // Interrupt and slice sizes
    // ==================================================

    // Number of interrupt lines, one per time slice
    localparam int NUM_IRQ = 16;

    // Width of the slice index and of an interrupt id
    localparam int SLICE_W = 4;

    // Width of a vector address
    localparam int ADDR_W = 32;

    // ==================================================
    // Vector table reset rule
    // ==================================================

    // Entry 0 after reset
    localparam logic [31:0] VEC_BASE = 32'hC000_0000;

    // Byte distance between adjacent entries after reset
    localparam int VEC_STRIDE = 64;

    // Reset value of one table entry
    function automatic logic [ADDR_W-1:0] vec_reset(input int unsigned idx);
        return VEC_BASE + ADDR_W'(idx) * ADDR_W'(VEC_STRIDE);
    endfunction

    // ==================================================
    // Slice timing
    // ==================================================

    // Clock cycles spent on each slice
    localparam int DWELL_CYCLES = 4;

endpackage

// File: design/ivmu_top.sv
module ivmu_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [ivmu_pkg::NUM_IRQ-1:0] irq_in,
    input  logic                        run,
    input  logic                        tbl_we,
    input  logic [ivmu_pkg::SLICE_W-1:0] tbl_idx,
    input  logic [ivmu_pkg::ADDR_W-1:0]  tbl_data,
    input  logic                        ready,
    output logic [ivmu_pkg::ADDR_W-1:0]  vector_addr,
    output logic [ivmu_pkg::SLICE_W-1:0] irq_id,
    output logic                        valid,
    output logic [ivmu_pkg::SLICE_W-1:0] time_slice
);

    import ivmu_pkg::*;

    // ==================================================
    // Internal wires
    // ==================================================

    // Captured edges waiting for their slice
    logic [NUM_IRQ-1:0] pending;

    // Candidate for the current slice
    logic              cand_valid;
    logic [SLICE_W-1:0] cand_id;
    logic [ADDR_W-1:0]  cand_addr;

    // Retire pulse from the output stage
    logic              issue;
    logic [SLICE_W-1:0] issue_id;

    // ==================================================
    // Blocks
    // ==================================================

    // Edge capture with clear on issue
    irq_pending u_irq_pending (
        .clk      (clk),
        .rst      (rst),
        .irq_in   (irq_in),
        .issue    (issue),
        .issue_id (issue_id),
        .pending  (pending)
    );

    // Slice stepping, also drives the top port
    slice_sequencer u_slice_sequencer (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .time_slice (time_slice)
    );

    // Table lookup for the one line allowed in this slice
    vector_table u_vector_table (
        .clk        (clk),
        .rst        (rst),
        .tbl_we     (tbl_we),
        .tbl_idx    (tbl_idx),
        .tbl_data   (tbl_data),
        .pending    (pending),
        .time_slice (time_slice),
        .cand_valid (cand_valid),
        .cand_id    (cand_id),
        .cand_addr  (cand_addr)
    );

    // Registered output with handshake
    vector_out_stage u_vector_out_stage (
        .clk         (clk),
        .rst         (rst),
        .ready       (ready),
        .cand_valid  (cand_valid),
        .cand_id     (cand_id),
        .cand_addr   (cand_addr),
        .valid       (valid),
        .irq_id      (irq_id),
        .vector_addr (vector_addr),
        .issue       (issue),
        .issue_id    (issue_id)
    );

endmodule

// File: design/slice_sequencer.sv
module slice_sequencer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        run,
    output logic [ivmu_pkg::SLICE_W-1:0] time_slice
);

    import ivmu_pkg::*;

    // Dwell counter width, at least one bit
    localparam int DWELL_W = (DWELL_CYCLES > 1) ? $clog2(DWELL_CYCLES) : 1;

    // Last count value before the slice moves on
    localparam logic [DWELL_W-1:0] DWELL_LAST = DWELL_W'(DWELL_CYCLES - 1);

    // ==================================================
    // Dwell and slice counters
    // ==================================================

    // Cycles already spent in the current slice
    logic [DWELL_W-1:0] dwell_cnt;

    // High on the last dwell cycle of a slice
    logic dwell_done;

    assign dwell_done = (dwell_cnt == DWELL_LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dwell_cnt  <= '0;
            time_slice <= '0;
        end else if (run) begin
            if (dwell_done) begin
                dwell_cnt  <= '0;
                // Natural wrap from 15 back to 0
                time_slice <= time_slice + 1'b1;
            end else begin
                dwell_cnt <= dwell_cnt + 1'b1;
            end
        end
        // Both counters hold while run is low
    end

endmodule

// File: design/vector_out_stage.sv
module vector_out_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        ready,
    input  logic                        cand_valid,
    input  logic [ivmu_pkg::SLICE_W-1:0] cand_id,
    input  logic [ivmu_pkg::ADDR_W-1:0]  cand_addr,
    output logic                        valid,
    output logic [ivmu_pkg::SLICE_W-1:0] irq_id,
    output logic [ivmu_pkg::ADDR_W-1:0]  vector_addr,
    output logic                        issue,
    output logic [ivmu_pkg::SLICE_W-1:0] issue_id
);

    // ==================================================
    // Valid/ready output register
    // ==================================================

    // Register is free when empty or when the consumer takes it now
    logic load;

    assign load = ~valid | ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid       <= 1'b0;
            irq_id      <= '0;
            vector_addr <= '0;
        end else if (load) begin
            valid       <= cand_valid;
            irq_id      <= cand_id;
            vector_addr <= cand_addr;
        end
        // Stalled output holds address and id
    end

    // ==================================================
    // Issue back to the pending bits
    // ==================================================

    // A real candidate is captured this cycle
    assign issue = load & cand_valid;

    // Index of the bit to retire
    assign issue_id = cand_id;

endmodule

// File: design/vector_table.sv
module vector_table (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        tbl_we,
    input  logic [ivmu_pkg::SLICE_W-1:0] tbl_idx,
    input  logic [ivmu_pkg::ADDR_W-1:0]  tbl_data,
    input  logic [ivmu_pkg::NUM_IRQ-1:0] pending,
    input  logic [ivmu_pkg::SLICE_W-1:0] time_slice,
    output logic                        cand_valid,
    output logic [ivmu_pkg::SLICE_W-1:0] cand_id,
    output logic [ivmu_pkg::ADDR_W-1:0]  cand_addr
);

    import ivmu_pkg::*;

    // ==================================================
    // Vector registers
    // ==================================================

    // One programmable vector per interrupt line
    logic [ADDR_W-1:0] vec_q [NUM_IRQ];

    // Reset loads base plus index times stride
    // A strobe rewrites one entry, visible from the next cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_IRQ; i++) begin
                vec_q[i] <= vec_reset(i);
            end
        end else if (tbl_we) begin
            vec_q[tbl_idx] <= tbl_data;
        end
    end

    // ==================================================
    // Slice masking and candidate selection
    // ==================================================

    // One-hot of the current slice
    logic [NUM_IRQ-1:0] slice_mask;

    // Pending bits that fall inside the slice, at most one set
    logic [NUM_IRQ-1:0] masked_irq;

    assign slice_mask = NUM_IRQ'(1) << time_slice;
    assign masked_irq = pending & slice_mask;

    // Any survivor is the candidate
    assign cand_valid = |masked_irq;

    // The only possible survivor sits at the slice index
    assign cand_id = time_slice;

    // Zero address when nothing is pending in this slice
    always_comb begin
        cand_addr = '0;
        if (cand_valid) begin
            cand_addr = vec_q[time_slice];
        end
    end

endmodule

// File: vlog.f
design/ivmu_pkg.sv
design/irq_pending.sv
design/slice_sequencer.sv
design/vector_table.sv
design/vector_out_stage.sv
design/ivmu_top.sv
bench/ivmu_properties.sv
bench/ivmu_tb.sv
